/* multihRot_consts.svh */
// ----------------------------------------------------------
// Width, frame and phase step macros for the derotator
// Quarter-wave (first octant) cosine and sine table
// ----------------------------------------------------------
`ifndef MULTIHROT_CONSTS_SVH
`define MULTIHROT_CONSTS_SVH

// Sample and angle widths
`define ROT_BITS    8
// 32 angle steps make one full turn
`define ANGLE_BITS  5
// Coefficients are signed and 127 stands for one
`define COEF_BITS   8

// Symbols per frame
`define FRAME_SYMS  64

// Phase steps of the two modulation indices, h = 4/16 and 5/16
`define H_STEP0     4
`define H_STEP1     5

// First octant of the unit circle in steps of 1/32 turn
`define COS_0  127
`define COS_1  125
`define COS_2  117
`define COS_3  106
`define COS_4  90
`define COS_5  71
`define COS_6  49
`define COS_7  25

`define SIN_0  0
`define SIN_1  25
`define SIN_2  49
`define SIN_3  71
`define SIN_4  90
`define SIN_5  106
`define SIN_6  117
`define SIN_7  125

`endif

/* cpmPkg.sv */
// ----------------------------------------------------------
// Modulation and control types of the CPM derotator
//   hIndex_t     selector of the current modulation index
//   ctrlState_t  states of the frame alignment controller
// ----------------------------------------------------------

package cpmPkg;

   // Index 0 is h = 4/16 and index 1 is h = 5/16
   // The multi-h cycle simply alternates between the two
   typedef logic hIndex_t;

   // IDLE    derotator disabled, angle held at zero
   // ALIGN   waiting for frameStart together with a symbol strobe
   // TRACK   locked, each symbol advances the phase
   typedef enum logic [1:0] {
      IDLE  = 2'd0,
      ALIGN = 2'd1,
      TRACK = 2'd2
   } ctrlState_t;

endpackage

/* rotPkg.sv */
// ----------------------------------------------------------
// Sample, coefficient and angle types of the rotator
//   sample_t      signed I or Q sample
//   coef_t        signed rotation coefficient
//   rotAngle_u    angle word, full index or quadrant/octant
// ----------------------------------------------------------
`include "multihRot_consts.svh"

package rotPkg;

   typedef logic signed [`ROT_BITS-1:0] sample_t;

   typedef logic signed [`COEF_BITS-1:0] coef_t;

   // Upper two bits pick a quarter turn, lower three the step
   // inside the first quadrant covered by the octant table
   typedef struct packed {
      logic [1:0] quadrant;
      logic [2:0] octant;
   } angleParts_t;

   // The accumulator works on the full index, while the rotator
   // decodes the same bits as quadrant plus octant step
   typedef union packed {
      logic [`ANGLE_BITS-1:0] full;
      angleParts_t            parts;
   } rotAngle_u;

endpackage

/* rotCtrlFsm.sv */
// ----------------------------------------------------------
// Frame alignment controller of the derotator
// Acquires the frame on frameStart, tracks the frame head,
// drops lock on a missing frameStart and issues the
// advance and clear pulses for counter and accumulator
// ----------------------------------------------------------
`timescale 1ns/10ps

module rotCtrlFsm (
   input  logic clk,
   input  logic reset,
   input  logic enable,
   input  logic symEn,
   input  logic frameStart,
   input  logic frameHead,
   output logic advance,
   output logic clear,
   output logic locked
);

   cpmPkg::ctrlState_t state;
   cpmPkg::ctrlState_t stateNext;

   // ----------------------------------------------------------
   // Next state and pulse decode
   // ----------------------------------------------------------
   // advance and clear are mutually exclusive by construction,
   // every branch raises at most one of them
   always_comb begin
      stateNext = state;
      advance   = 1'b0;
      clear     = 1'b0;
      if (!enable) begin
         // Leaving any active state zeroes angle and count
         stateNext = cpmPkg::IDLE;
         clear     = (state != cpmPkg::IDLE);
      end else begin
         case (state)
            cpmPkg::IDLE: begin
               stateNext = cpmPkg::ALIGN;
            end
            cpmPkg::ALIGN: begin
               // First symbol of the frame starts the phase walk
               if (symEn && frameStart) begin
                  advance   = 1'b1;
                  stateNext = cpmPkg::TRACK;
               end
            end
            cpmPkg::TRACK: begin
               if (symEn) begin
                  // Frame head without frameStart means alignment is lost
                  if (frameHead && !frameStart) begin
                     clear     = 1'b1;
                     stateNext = cpmPkg::ALIGN;
                  end else begin
                     advance = 1'b1;
                  end
               end
            end
            default: begin
               stateNext = cpmPkg::IDLE;
            end
         endcase
      end
   end

   // ----------------------------------------------------------
   // State and lock registers
   // ----------------------------------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         state  <= cpmPkg::IDLE;
         locked <= 1'b0;
      end else begin
         state  <= stateNext;
         // Follows the state register so lock is high exactly in TRACK
         locked <= (stateNext == cpmPkg::TRACK);
      end
   end

endmodule

/* symbolCounter.sv */
// ----------------------------------------------------------
// Symbol position counter within the frame
// Gives the multi-h index and the frame head flag
// ----------------------------------------------------------
`timescale 1ns/10ps
`include "multihRot_consts.svh"

module symbolCounter (
   input  logic            clk,
   input  logic            reset,
   input  logic            advance,
   input  logic            clear,
   output cpmPkg::hIndex_t hIndex,
   output logic            frameHead
);

   localparam int CNT_BITS = $clog2(`FRAME_SYMS);

   logic [CNT_BITS-1:0] symCount;

   // Counts advance pulses only, the controller already
   // qualified them with symEn and the lock state
   always_ff @(posedge clk) begin
      if (reset || clear) begin
         symCount <= '0;
      end else if (advance) begin
         if (symCount == CNT_BITS'(`FRAME_SYMS - 1)) begin
            symCount <= '0;
         end else begin
            symCount <= symCount + 1'b1;
         end
      end
   end

   // Two indices alternate, so the low count bit picks the index
   assign hIndex = symCount[0];

   // Count zero is the slot where the next frameStart is expected
   assign frameHead = (symCount == '0);

endmodule

/* phaseAccumulator.sv */
// ----------------------------------------------------------
// Modulo-32 derotation angle register
// Steps by 4 or 5 units per symbol, direction from dataBit
// ----------------------------------------------------------
`timescale 1ns/10ps
`include "multihRot_consts.svh"

module phaseAccumulator (
   input  logic               clk,
   input  logic               reset,
   input  logic               advance,
   input  logic               clear,
   input  logic               dataBit,
   input  cpmPkg::hIndex_t    hIndex,
   output rotPkg::rotAngle_u  angle
);

   logic [`ANGLE_BITS-1:0] step;

   // Phase step of the modulation index in use for this symbol
   assign step = hIndex ? `ANGLE_BITS'(`H_STEP1) : `ANGLE_BITS'(`H_STEP0);

   // ----------------------------------------------------------
   // Angle register
   // ----------------------------------------------------------
   // The derotator undoes the transmitted phase, so a one bit
   // (positive frequency) steps the angle backwards
   // Wrap past 31 is the natural overflow of the 5-bit word
   always_ff @(posedge clk) begin
      if (reset || clear) begin
         angle.full <= '0;
      end else if (advance) begin
         if (dataBit) begin
            angle.full <= angle.full - step;
         end else begin
            angle.full <= angle.full + step;
         end
      end
   end

endmodule

/* phaseRotator.sv */
// ----------------------------------------------------------
// Three-stage complex rotator
//   stage 1  quadrant pre-rotation and octant coefficients
//   stage 2  four signed products
//   stage 3  sum, difference, scale by 1/128, saturate
// Symbol strobes are delayed to stay aligned with the data
// ----------------------------------------------------------
`timescale 1ns/10ps
`include "multihRot_consts.svh"

module phaseRotator (
   input  logic              clk,
   input  logic              reset,
   input  logic              symEn,
   input  logic              sym2xEn,
   input  rotPkg::sample_t   i,
   input  rotPkg::sample_t   q,
   input  rotPkg::rotAngle_u angle,
   output logic              symEnOut,
   output logic              sym2xEnOut,
   output rotPkg::sample_t   iOut,
   output rotPkg::sample_t   qOut
);

   localparam int PROD_BITS   = `ROT_BITS + `COEF_BITS;
   localparam int SUM_BITS    = PROD_BITS + 1;
   // 127 stands for one, so the products are scaled by 1/128
   localparam int SHIFT       = `COEF_BITS - 1;
   localparam int SCALED_BITS = SUM_BITS - SHIFT;
   localparam int SAMPLE_MAX  = 2**(`ROT_BITS-1) - 1;
   localparam int SAMPLE_MIN  = -(2**(`ROT_BITS-1));
   localparam int PIPE_DEPTH  = 3;

   // Negation that maps the most negative sample to the maximum
   function automatic rotPkg::sample_t negSat(input rotPkg::sample_t x);
      if (x == rotPkg::sample_t'(SAMPLE_MIN)) begin
         return rotPkg::sample_t'(SAMPLE_MAX);
      end
      return -x;
   endfunction

   // Clamp of the scaled sum into the sample range
   function automatic rotPkg::sample_t sat(input logic signed [SCALED_BITS-1:0] x);
      if (x > SCALED_BITS'(SAMPLE_MAX)) begin
         return rotPkg::sample_t'(SAMPLE_MAX);
      end else if (x < SCALED_BITS'(SAMPLE_MIN)) begin
         return rotPkg::sample_t'(SAMPLE_MIN);
      end
      return x[`ROT_BITS-1:0];
   endfunction

   // ----------------------------------------------------------
   // Stage 1: quarter-turn pre-rotation and table lookup
   // ----------------------------------------------------------
   rotPkg::sample_t aNext, bNext;
   rotPkg::coef_t   cNext, sNext;
   rotPkg::sample_t aReg, bReg;
   rotPkg::coef_t   cReg, sReg;

   // Multiples of 90 degrees cost no multiplier, only a swap and
   // negation, which leaves the table to cover one quadrant
   always_comb begin
      case (angle.parts.quadrant)
         2'd0: begin
            aNext = i;
            bNext = q;
         end
         2'd1: begin
            aNext = negSat(q);
            bNext = i;
         end
         2'd2: begin
            aNext = negSat(i);
            bNext = negSat(q);
         end
         default: begin
            aNext = q;
            bNext = negSat(i);
         end
      endcase
   end

   // Octant step picks the cosine and sine of the residual angle
   always_comb begin
      case (angle.parts.octant)
         3'd0: begin
            cNext = `COEF_BITS'(`COS_0);
            sNext = `COEF_BITS'(`SIN_0);
         end
         3'd1: begin
            cNext = `COEF_BITS'(`COS_1);
            sNext = `COEF_BITS'(`SIN_1);
         end
         3'd2: begin
            cNext = `COEF_BITS'(`COS_2);
            sNext = `COEF_BITS'(`SIN_2);
         end
         3'd3: begin
            cNext = `COEF_BITS'(`COS_3);
            sNext = `COEF_BITS'(`SIN_3);
         end
         3'd4: begin
            cNext = `COEF_BITS'(`COS_4);
            sNext = `COEF_BITS'(`SIN_4);
         end
         3'd5: begin
            cNext = `COEF_BITS'(`COS_5);
            sNext = `COEF_BITS'(`SIN_5);
         end
         3'd6: begin
            cNext = `COEF_BITS'(`COS_6);
            sNext = `COEF_BITS'(`SIN_6);
         end
         default: begin
            cNext = `COEF_BITS'(`COS_7);
            sNext = `COEF_BITS'(`SIN_7);
         end
      endcase
   end

   always_ff @(posedge clk) begin
      aReg <= aNext;
      bReg <= bNext;
      cReg <= cNext;
      sReg <= sNext;
   end

   // ----------------------------------------------------------
   // Stage 2: the four products of the complex multiply
   // ----------------------------------------------------------
   logic signed [PROD_BITS-1:0] acProd, bsProd, asProd, bcProd;

   always_ff @(posedge clk) begin
      acProd <= aReg * cReg;
      bsProd <= bReg * sReg;
      asProd <= aReg * sReg;
      bcProd <= bReg * cReg;
   end

   // ----------------------------------------------------------
   // Stage 3: combine, scale and saturate
   // ----------------------------------------------------------
   logic signed [SUM_BITS-1:0]    iSum, qSum;
   logic signed [SCALED_BITS-1:0] iScaled, qScaled;

   // One extra bit holds the sum of two full-scale products
   assign iSum = acProd - bsProd;
   assign qSum = asProd + bcProd;

   // Dropping the low bits of a two's complement word rounds
   // towards minus infinity, the floor of the division by 128
   assign iScaled = iSum[SUM_BITS-1:SHIFT];
   assign qScaled = qSum[SUM_BITS-1:SHIFT];

   always_ff @(posedge clk) begin
      if (reset) begin
         iOut <= '0;
         qOut <= '0;
      end else begin
         iOut <= sat(iScaled);
         qOut <= sat(qScaled);
      end
   end

   // ----------------------------------------------------------
   // Strobe delay matching the data pipeline
   // ----------------------------------------------------------
   logic [PIPE_DEPTH-1:0] symEnSr, sym2xEnSr;

   always_ff @(posedge clk) begin
      if (reset) begin
         symEnSr   <= '0;
         sym2xEnSr <= '0;
      end else begin
         symEnSr   <= {symEnSr[PIPE_DEPTH-2:0], symEn};
         sym2xEnSr <= {sym2xEnSr[PIPE_DEPTH-2:0], sym2xEn};
      end
   end

   assign symEnOut   = symEnSr[PIPE_DEPTH-1];
   assign sym2xEnOut = sym2xEnSr[PIPE_DEPTH-1];

endmodule

/* multihDerotator.sv */
// ----------------------------------------------------------
// Multi-h CPM phase derotator, top level
// Controller, symbol counter, phase accumulator, rotator
// ----------------------------------------------------------
`timescale 1ns/10ps

module multihDerotator (
   input  logic            clk,
   input  logic            reset,
   input  logic            enable,
   input  logic            symEn,
   input  logic            sym2xEn,
   input  logic            frameStart,
   input  logic            dataBit,
   input  rotPkg::sample_t i,
   input  rotPkg::sample_t q,
   output rotPkg::sample_t iOut,
   output rotPkg::sample_t qOut,
   output logic            symEnOut,
   output logic            sym2xEnOut,
   output logic            locked
);

   // Control pulses from the FSM, never high together
   logic              advance;
   logic              clear;
   logic              frameHead;
   cpmPkg::hIndex_t   hIndex;
   rotPkg::rotAngle_u angle;

   // Frame alignment and lock tracking
   rotCtrlFsm uCtrl (
      .clk        (clk),
      .reset      (reset),
      .enable     (enable),
      .symEn      (symEn),
      .frameStart (frameStart),
      .frameHead  (frameHead),
      .advance    (advance),
      .clear      (clear),
      .locked     (locked)
   );

   // Position in the frame selects the modulation index
   symbolCounter uCount (
      .clk       (clk),
      .reset     (reset),
      .advance   (advance),
      .clear     (clear),
      .hIndex    (hIndex),
      .frameHead (frameHead)
   );

   phaseAccumulator uAccum (
      .clk     (clk),
      .reset   (reset),
      .advance (advance),
      .clear   (clear),
      .dataBit (dataBit),
      .hIndex  (hIndex),
      .angle   (angle)
   );

   // Runs every clock, the strobes ride along with the samples
   phaseRotator uRot (
      .clk        (clk),
      .reset      (reset),
      .symEn      (symEn),
      .sym2xEn    (sym2xEn),
      .i          (i),
      .q          (q),
      .angle      (angle),
      .symEnOut   (symEnOut),
      .sym2xEnOut (sym2xEnOut),
      .iOut       (iOut),
      .qOut       (qOut)
   );

endmodule

/* multihDerotator_assertions.sv */
// ----------------------------------------------------------
// Concurrent assertions bound into the derotator top level
//   symbol strobe latency through the rotator
//   lock only after a frameStart
//   angle moves only after advance or clear
// ----------------------------------------------------------
`timescale 1ns/10ps

module multihDerotator_assertions (
   input logic              clk,
   input logic              reset,
   input logic              symEn,
   input logic              frameStart,
   input logic              symEnOut,
   input logic              locked,
   input logic              advance,
   input logic              clear,
   input rotPkg::rotAngle_u angle
);

   // The rotator is three registers deep for data and strobes alike
   strobeLatency: assert property (
      @(posedge clk) disable iff (reset)
      symEnOut == $past(symEn, 3)
   ) else $error("symEnOut does not follow symEn by three cycles");

   // Acquisition needs frameStart together with the symbol strobe
   lockNeedsFrameStart: assert property (
      @(posedge clk) disable iff (reset)
      $rose(locked) |-> $past(frameStart)
   ) else $error("locked rose without frameStart on the previous cycle");

   angleStepsOnPulse: assert property (
      @(posedge clk) disable iff (reset)
      $changed(angle.full) |-> $past(advance || clear)
   ) else $error("angle changed without an advance or clear pulse");

endmodule

/* multihDerotator_tb.sv */
// ----------------------------------------------------------
// Directed testbench of the multi-h CPM derotator
//   reference model of controller, counter and angle
//   rotate function on the shared coefficient table
//   per-cycle output checker, six directed tests, watchdog
// ----------------------------------------------------------
`timescale 1ns/10ps
`include "multihRot_consts.svh"

module multihDerotator_tb;

   localparam int CLK_PERIOD = 20;
   localparam int SYM_CYCLES = 4;
   // Symbols per test in order, idle and hold cycles rounded up to symbols
   localparam int TEST_SYMS  = 12 + 12 + 40 + 12 + 136 + 18;
   localparam int TIMEOUT_NS = 2 * TEST_SYMS * SYM_CYCLES * CLK_PERIOD;

   logic            clk;
   logic            reset;
   logic            enable;
   logic            symEn;
   logic            sym2xEn;
   logic            frameStart;
   logic            dataBit;
   rotPkg::sample_t iIn;
   rotPkg::sample_t qIn;
   rotPkg::sample_t iOut;
   rotPkg::sample_t qOut;
   logic            symEnOut;
   logic            sym2xEnOut;
   logic            locked;

   int nChecks;
   int nErrors;
   bit checkOn;

   // Model state, 0 is IDLE, 1 is ALIGN and 2 is TRACK
   int mState;
   int mCount;
   int mAngle;
   // Bit n is set once the DUT angle has been seen in quadrant n
   int quadSeen;

   // Index 0 holds the newest sample, index 2 the one now at the outputs
   int   expI     [3];
   int   expQ     [3];
   logic expSym   [3];
   logic expSym2x [3];

   int cosTab [8] = '{`COS_0, `COS_1, `COS_2, `COS_3, `COS_4, `COS_5, `COS_6, `COS_7};
   int sinTab [8] = '{`SIN_0, `SIN_1, `SIN_2, `SIN_3, `SIN_4, `SIN_5, `SIN_6, `SIN_7};

   multihDerotator DUT (
      .clk        (clk),
      .reset      (reset),
      .enable     (enable),
      .symEn      (symEn),
      .sym2xEn    (sym2xEn),
      .frameStart (frameStart),
      .dataBit    (dataBit),
      .i          (iIn),
      .q          (qIn),
      .iOut       (iOut),
      .qOut       (qOut),
      .symEnOut   (symEnOut),
      .sym2xEnOut (sym2xEnOut),
      .locked     (locked)
   );

   bind multihDerotator multihDerotator_assertions uAssert (
      .clk        (clk),
      .reset      (reset),
      .symEn      (symEn),
      .frameStart (frameStart),
      .symEnOut   (symEnOut),
      .locked     (locked),
      .advance    (advance),
      .clear      (clear),
      .angle      (angle)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   initial begin
      #(TIMEOUT_NS);
      $display("Timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
      $display("CHECKS FAILED");
      $finish;
   end

   // ----------------------------------------------------------
   // Reference arithmetic
   // ----------------------------------------------------------
   function automatic int clampSample(input int x);
      if (x > 127) begin
         return 127;
      end
      if (x < -128) begin
         return -128;
      end
      return x;
   endfunction

   // Integer division rounds toward zero, so negative remainders step down
   function automatic int floorDiv128(input int x);
      int qt;
      qt = x / 128;
      if ((x < 0) && (qt * 128 != x)) begin
         qt = qt - 1;
      end
      return qt;
   endfunction

   // Quarter-turn pre-rotation, then the octant step from the table
   function automatic void rotate(input int iv, input int qv, input int ang,
                                  output int ir, output int qr);
      int a;
      int b;
      int c;
      int s;
      case (ang / 8)
         0: begin
            a = iv;
            b = qv;
         end
         1: begin
            a = clampSample(-qv);
            b = iv;
         end
         2: begin
            a = clampSample(-iv);
            b = clampSample(-qv);
         end
         default: begin
            a = qv;
            b = clampSample(-iv);
         end
      endcase
      c = cosTab[ang % 8];
      s = sinTab[ang % 8];
      ir = clampSample(floorDiv128(a * c - b * s));
      qr = clampSample(floorDiv128(a * s + b * c));
   endfunction

   function automatic int randomSample();
      return int'($urandom % 256) - 128;
   endfunction

   function automatic logic randomBit();
      return ($urandom % 2) != 0;
   endfunction

   task automatic compareValue(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
      nChecks++;
      if (got !== expected) begin
         nErrors++;
         $display("FAILED %s: got 0x%0h, expected 0x%0h at %0t", name, got, expected,
                  $time);
      end
   endtask

   // ----------------------------------------------------------
   // Model, updated at each rising edge from the driven inputs
   // ----------------------------------------------------------
   always @(posedge clk) begin
      int   ir;
      int   qr;
      int   nextState;
      logic adv;
      logic clr;
      rotate(iIn, qIn, mAngle, ir, qr);
      for (int k = 2; k > 0; k--) begin
         expI[k]     = expI[k-1];
         expQ[k]     = expQ[k-1];
         expSym[k]   = expSym[k-1];
         expSym2x[k] = expSym2x[k-1];
      end
      expI[0]     = ir;
      expQ[0]     = qr;
      expSym[0]   = symEn;
      expSym2x[0] = sym2xEn;
      if (reset) begin
         mState = 0;
         mCount = 0;
         mAngle = 0;
      end else begin
         nextState = mState;
         adv       = 1'b0;
         clr       = 1'b0;
         if (!enable) begin
            nextState = 0;
            clr       = (mState != 0);
         end else if (mState == 0) begin
            nextState = 1;
         end else if (mState == 1) begin
            if (symEn && frameStart) begin
               adv       = 1'b1;
               nextState = 2;
            end
         end else if (symEn) begin
            // A frame head without frameStart means the frame was lost
            if ((mCount == 0) && !frameStart) begin
               clr       = 1'b1;
               nextState = 1;
            end else begin
               adv = 1'b1;
            end
         end
         if (clr) begin
            mCount = 0;
            mAngle = 0;
         end else if (adv) begin
            if (dataBit) begin
               mAngle = (mAngle + 32 - ((mCount % 2) ? `H_STEP1 : `H_STEP0)) % 32;
            end else begin
               mAngle = (mAngle + ((mCount % 2) ? `H_STEP1 : `H_STEP0)) % 32;
            end
            mCount = (mCount + 1) % `FRAME_SYMS;
         end
         mState = nextState;
      end
   end

   // Outputs settle after the rising edge, so they are compared at the falling edge
   always @(negedge clk) begin
      if (checkOn) begin
         compareValue("iOut", iOut, expI[2]);
         compareValue("qOut", qOut, expQ[2]);
         compareValue("symEnOut", symEnOut, expSym[2]);
         compareValue("sym2xEnOut", sym2xEnOut, expSym2x[2]);
         compareValue("locked", locked, mState == 2);
         compareValue("angle", DUT.angle.full, mAngle);
         quadSeen = quadSeen | (1 << DUT.angle.parts.quadrant);
      end
   end

   // ----------------------------------------------------------
   // Stimulus helpers
   // ----------------------------------------------------------
   task automatic driveCycle(input logic se, input logic s2x, input logic fs,
                             input logic db, input int iv, input int qv);
      @(posedge clk);
      #1;
      symEn      = se;
      sym2xEn    = s2x;
      frameStart = fs;
      dataBit    = db;
      iIn        = rotPkg::sample_t'(iv);
      qIn        = rotPkg::sample_t'(qv);
   endtask

   // Symbol strobe on the first cycle, half-symbol strobe on cycles 0 and 2
   task automatic runSymbol(input logic fs, input logic db, input bit randIq,
                            input int iv, input int qv);
      int ri;
      int rq;
      for (int c = 0; c < SYM_CYCLES; c++) begin
         ri = iv;
         rq = qv;
         if (randIq) begin
            ri = randomSample();
            rq = randomSample();
         end
         driveCycle(c == 0, (c % 2) == 0, fs && (c == 0), db, ri, rq);
      end
   endtask

   // Ends once the first held sample sits on the outputs
   task automatic holdSample(input int iv, input int qv);
      repeat (SYM_CYCLES) driveCycle(1'b0, 1'b0, 1'b0, 1'b0, iv, qv);
      repeat (1) @(negedge clk);
   endtask

   task automatic restartControl();
      enable = 1'b0;
      repeat (2) driveCycle(1'b0, 1'b0, 1'b0, 1'b0, 0, 0);
      enable = 1'b1;
      repeat (2) driveCycle(1'b0, 1'b0, 1'b0, 1'b0, 0, 0);
   endtask

   // ----------------------------------------------------------
   // Directed tests
   // ----------------------------------------------------------
   task automatic testResetIdle();
      compareValue("iOut", iOut, 0);
      compareValue("qOut", qOut, 0);
      compareValue("symEnOut", symEnOut, 0);
      compareValue("sym2xEnOut", sym2xEnOut, 0);
      compareValue("locked", locked, 0);
      // frameStart is ignored while the derotator is disabled
      repeat (12) runSymbol(1'b1, randomBit(), 1'b1, 0, 0);
      compareValue("locked", locked, 0);
      compareValue("angle", DUT.angle.full, 0);
   endtask

   task automatic testStrobeAlign();
      repeat (8) runSymbol(1'b0, 1'b0, 1'b1, 0, 0);
      // Irregular and back-to-back strobes
      for (int k = 0; k < 16; k++) begin
         driveCycle(randomBit(), randomBit(), 1'b0, 1'b0, randomSample(), randomSample());
      end
   endtask

   task automatic testAcquireStep();
      enable = 1'b1;
      repeat (2) driveCycle(1'b0, 1'b0, 1'b0, 1'b0, 100, 0);
      runSymbol(1'b1, 1'b0, 1'b0, 100, 0);
      compareValue("locked", locked, 1);
      quadSeen = 0;
      // Eight steps forward walk once around the circle
      repeat (8) runSymbol(1'b0, 1'b0, 1'b0, 100, 0);
      repeat (30) runSymbol(1'b0, randomBit(), 1'b0, 100, 0);
      compareValue("quadrantsVisited", quadSeen, 4'hf);
   endtask

   task automatic testSaturation();
      restartControl();
      runSymbol(1'b1, 1'b0, 1'b0, 0, 0);
      compareValue("angle", DUT.angle.full, 4);
      // c = s = 90, so qOut = floor(22860 / 128) = 178 clamps to 127
      holdSample(127, 127);
      compareValue("iOut", iOut, 0);
      compareValue("qOut", qOut, 127);
      // Steps 5, 4, 5 bring the angle to 18, quadrant 2 octant 2
      repeat (3) runSymbol(1'b0, 1'b0, 1'b0, 0, 0);
      compareValue("angle", DUT.angle.full, 18);
      // Negation clamps to (127, 127), then c = 117 and s = 49
      holdSample(-128, -128);
      compareValue("iOut", iOut, 67);
      compareValue("qOut", qOut, 127);
   endtask

   task automatic testFrameTracking();
      restartControl();
      runSymbol(1'b1, randomBit(), 1'b0, 100, 0);
      // Two frames with frameStart at each head and one stray frameStart
      for (int k = 0; k < 2 * `FRAME_SYMS - 1; k++) begin
         runSymbol((mCount == 0) || (k == 70), randomBit(), 1'b0, 100, 0);
         compareValue("locked", locked, 1);
      end
      // Missing frameStart at the head
      runSymbol(1'b0, randomBit(), 1'b0, 100, 0);
      compareValue("locked", locked, 0);
      compareValue("angle", DUT.angle.full, 0);
      repeat (4) runSymbol(1'b0, randomBit(), 1'b0, 100, 0);
      compareValue("angle", DUT.angle.full, 0);
   endtask

   task automatic testEnableDrop();
      runSymbol(1'b1, 1'b0, 1'b0, 100, 0);
      repeat (10) runSymbol(1'b0, randomBit(), 1'b0, 100, 0);
      enable = 1'b0;
      repeat (2) driveCycle(1'b0, 1'b0, 1'b0, 1'b0, 100, 0);
      compareValue("locked", locked, 0);
      compareValue("angle", DUT.angle.full, 0);
      enable = 1'b1;
      repeat (2) driveCycle(1'b0, 1'b0, 1'b0, 1'b0, 100, 0);
      // Re-acquisition starts again with the first index
      runSymbol(1'b1, 1'b0, 1'b0, 100, 0);
      compareValue("angle", DUT.angle.full, `H_STEP0);
      runSymbol(1'b0, 1'b0, 1'b0, 100, 0);
      compareValue("angle", DUT.angle.full, `H_STEP0 + `H_STEP1);
   endtask

   // ----------------------------------------------------------
   // Test sequence
   // ----------------------------------------------------------
   initial begin
      void'($urandom(32'h3d48));
      nChecks    = 0;
      nErrors    = 0;
      checkOn    = 1'b0;
      quadSeen   = 0;
      reset      = 1'b1;
      enable     = 1'b0;
      symEn      = 1'b0;
      sym2xEn    = 1'b0;
      frameStart = 1'b0;
      dataBit    = 1'b0;
      iIn        = '0;
      qIn        = '0;
      repeat (4) @(posedge clk);
      #1;
      reset   = 1'b0;
      checkOn = 1'b1;
      testResetIdle();
      testStrobeAlign();
      testAcquireStep();
      testSaturation();
      testFrameTracking();
      testEnableDrop();
      $display("Summary: %0d checks, %0d errors", nChecks, nErrors);
      if (nErrors == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

/* multihDerotator.f */
+incdir+.
cpmPkg.sv
rotPkg.sv
rotCtrlFsm.sv
symbolCounter.sv
phaseAccumulator.sv
phaseRotator.sv
multihDerotator.sv
multihDerotator_assertions.sv
multihDerotator_tb.sv

/* Makefile */
TOP = multihDerotator_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f multihDerotator.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "CHECKS FAILED" sim.log; then echo "Simulation reported failures"; exit 1; fi
	@if ! grep -q "ALL CHECKS PASSED" sim.log; then echo "Simulation did not complete"; exit 1; fi

lint:
	verilator --lint-only --timing --assert -Wall -f multihDerotator.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
